// File: flist.f
+incdir+src
src/codebook_sym_pkg.sv
src/codebook_code_pkg.sv
src/codebook_length_rom.sv
src/codebook_codeword_rom.sv
src/codebook_output_stage.sv
src/codebook_encoder_b11.sv
tb/codebook_encoder_b11_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f \
    --top-module codebook_encoder_b11_tb -o codebook_encoder_b11_sim

./obj_dir/codebook_encoder_b11_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed, see sim.log."
    exit 1
fi
echo "Simulation passed."

// File: tb/codebook_encoder_b11_tb.sv
`include "codebook_macros.svh"

module codebook_encoder_b11_tb;

    localparam int RESET_CYCLES   = 8;
    localparam int N_REF          = 40;
    localparam int N_KEYS         = 87;
    localparam int N_RAND         = 200;
    localparam int TIMEOUT_CYCLES = 400;  // About 252 cycles of stimulus plus margin.

    typedef struct packed {
        codebook_sym_pkg::sym_group_t  grp;
        codebook_code_pkg::code_len_t  len;
        codebook_code_pkg::code_bits_t bits;
    } ref_entry_t;

    logic                            clk_i;
    logic                            rst_n_i;
    codebook_sym_pkg::sym_group_t    sym_i;
    codebook_code_pkg::code_result_t code_o;

    // --------------------
    // Reference data
    // --------------------

    // Count, key, length and codeword of the directed entries.
    logic [63:0] ref_tab [0:N_REF-1] = '{
        {6'd1, 32'h00000001, 5'd5,  21'b10000},
        {6'd1, 32'h0000000F, 5'd14, 21'b11111111110100},
        {6'd2, 32'h00000021, 5'd11, 21'b11111010000},
        {6'd2, 32'h00000022, 5'd11, 21'b11111010001},
        {6'd2, 32'h0000000F, 5'd14, 21'b11111111110101},
        {6'd2, 32'h0000002F, 5'd20, 21'b11111111111111101100},
        {6'd3, 32'h00000002, 5'd6,  21'b100010},
        {6'd3, 32'h00000200, 5'd6,  21'b100100},
        {6'd3, 32'h00000201, 5'd11, 21'b11111010110},
        {6'd3, 32'h0000000F, 5'd14, 21'b11111111110110},
        {6'd3, 32'h0000001F, 5'd19, 21'b1111111111111110000},
        {6'd3, 32'h0000020F, 5'd20, 21'b11111111111111101110},
        {6'd4, 32'h00000002, 5'd6,  21'b100101},
        {6'd4, 32'h00000102, 5'd11, 21'b11111011011},
        {6'd4, 32'h0000000F, 5'd14, 21'b11111111110111},
        {6'd4, 32'h0000010F, 5'd19, 21'b1111111111111110010},
        {6'd4, 32'h0000001F, 5'd19, 21'b1111111111111110001},
        {6'd5, 32'h00000002, 5'd6,  21'b100110},
        {6'd5, 32'h00001001, 5'd11, 21'b11111100000},
        {6'd5, 32'h00001002, 5'd11, 21'b11111100001},
        {6'd5, 32'h0000000F, 5'd14, 21'b11111111111000},
        {6'd5, 32'h0000100F, 5'd19, 21'b1111111111111110101},
        {6'd6, 32'h00000002, 5'd6,  21'b100111},
        {6'd6, 32'h00010001, 5'd11, 21'b11111101000},
        {6'd6, 32'h00010002, 5'd11, 21'b11111101001},
        {6'd6, 32'h0000000F, 5'd14, 21'b11111111111001},
        {6'd6, 32'h0000001F, 5'd20, 21'b11111111111111101111},
        {6'd6, 32'h0001000F, 5'd20, 21'b11111111111111110010},
        {6'd7, 32'h00000002, 5'd6,  21'b101000},
        {6'd7, 32'h00010000, 5'd6,  21'b101011},
        {6'd7, 32'h00100002, 5'd11, 21'b11111110011},
        {6'd7, 32'h0000000F, 5'd14, 21'b11111111111010},
        {6'd7, 32'h0010000F, 5'd20, 21'b11111111111111110111},
        {6'd8, 32'h00000001, 5'd6,  21'b101100},
        {6'd8, 32'h01000000, 5'd6,  21'b110000},
        {6'd8, 32'h01000001, 5'd11, 21'b11111111000},
        {6'd8, 32'h01000002, 5'd12, 21'b111111110010},
        {6'd8, 32'h0000000F, 5'd15, 21'b111111111110110},
        {6'd8, 32'h0000001F, 5'd20, 21'b11111111111111111000},
        {6'd8, 32'h0100000F, 5'd20, 21'b11111111111111111010}
    };

    // Every listed group, count in the top byte and key below it.
    logic [39:0] key_list [0:N_KEYS-1] = '{
        40'h01_00000001, 40'h01_0000000F,
        40'h02_00000021, 40'h02_00000022, 40'h02_0000000F, 40'h02_0000002F,
        40'h03_00000002, 40'h03_00000200, 40'h03_00000020, 40'h03_00000201,
        40'h03_00000011, 40'h03_00000202, 40'h03_00000012, 40'h03_00000021,
        40'h03_00000022, 40'h03_0000000F, 40'h03_0000001F, 40'h03_0000020F,
        40'h03_0000002F,
        40'h04_00000002, 40'h04_00000102, 40'h04_00000011, 40'h04_00000012,
        40'h04_00000101, 40'h04_0000000F, 40'h04_0000010F, 40'h04_0000001F,
        40'h05_00000002, 40'h05_00000102, 40'h05_00000011, 40'h05_00001001,
        40'h05_00000012, 40'h05_00001002, 40'h05_00000101, 40'h05_0000000F,
        40'h05_0000010F, 40'h05_0000100F, 40'h05_0000001F,
        40'h06_00000002, 40'h06_00000101, 40'h06_00000102, 40'h06_00000011,
        40'h06_00001001, 40'h06_00000012, 40'h06_00001002, 40'h06_00010001,
        40'h06_00010002, 40'h06_0000000F, 40'h06_0000010F, 40'h06_0000100F,
        40'h06_0000001F, 40'h06_0001000F,
        40'h07_00000002, 40'h07_00001000, 40'h07_00010000, 40'h07_00000100,
        40'h07_00000101, 40'h07_00000102, 40'h07_00000011, 40'h07_00001001,
        40'h07_00000012, 40'h07_00001002, 40'h07_00010001, 40'h07_00010002,
        40'h07_00100001, 40'h07_00100002, 40'h07_0000000F, 40'h07_0000010F,
        40'h07_0000100F, 40'h07_0000001F, 40'h07_0001000F, 40'h07_0010000F,
        40'h08_00000001, 40'h08_00000002, 40'h08_00000010, 40'h08_01000000,
        40'h08_00000100, 40'h08_00000101, 40'h08_00000102, 40'h08_00000011,
        40'h08_00000012, 40'h08_01000001, 40'h08_01000002, 40'h08_0000000F,
        40'h08_0000010F, 40'h08_0000001F, 40'h08_0100000F
    };

    logic [31:0]                     lfsr_state;
    int                              errors = 0;
    int                              groups = 0;
    int                              cycle_cnt = 0;
    int                              ref_idx;
    logic                            listed;
    ref_entry_t                      hit_entry;
    codebook_code_pkg::code_result_t exp_d;
    codebook_code_pkg::code_result_t exp_q = '0;
    logic                            hit_d;
    logic                            miss_d;
    logic                            hit_q = 1'b0;
    logic                            miss_q = 1'b0;
    logic                            rst_d_q = 1'b0;
    logic                            started_q = 1'b0;

    codebook_encoder_b11 codebook_encoder_b11_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .sym_i   (sym_i),
        .code_o  (code_o)
    );

    // --------------------
    // Helpers
    // --------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit, newest bit at the bottom.
    task automatic draw_bits(input int n, output logic [31:0] val);
        int b;
        val = '0;
        for (b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [31:0] digit_mask(input codebook_sym_pkg::sym_cnt_t cnt);
        int shift;
        shift = int'(cnt) * 4;
        if (shift >= 32) begin
            return '1;
        end
        return (32'h1 << shift) - 32'h1;
    endfunction

    function automatic int find_ref(input codebook_sym_pkg::sym_group_t grp);
        ref_entry_t e;
        int         k;
        for (k = 0; k < N_REF; k++) begin
            e = ref_tab[k];
            if (e.grp == grp) begin
                return k;
            end
        end
        return -1;
    endfunction

    function automatic logic in_key_list(input codebook_sym_pkg::sym_group_t grp);
        int k;
        for (k = 0; k < N_KEYS; k++) begin
            if (key_list[k] == {2'b00, grp}) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("[FAIL] %s exp=%h act=%h", name, exp, act);
    endtask

    // --------------------
    // Expected results
    // --------------------

    // A listed group without directed data only gets the shape checks.
    always_comb begin
        ref_idx   = find_ref(sym_i);
        listed    = in_key_list(sym_i);
        hit_entry = '0;
        exp_d     = '0;
        hit_d     = 1'b0;
        miss_d    = 1'b0;
        if (ref_idx >= 0) begin
            hit_entry = ref_tab[ref_idx];
            exp_d     = {1'b1, hit_entry.len, hit_entry.bits};
            hit_d     = 1'b1;
        end else if (sym_i.cnt == '0 || sym_i.cnt > `CB_CNT_MAX || !listed) begin
            miss_d = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        started_q <= 1'b1;
        rst_d_q   <= !rst_n_i;
        if (!rst_n_i) begin
            exp_q  <= '0;
            hit_q  <= 1'b0;
            miss_q <= 1'b0;
        end else begin
            exp_q  <= exp_d;
            hit_q  <= hit_d;
            miss_q <= miss_d;
        end
    end

    // --------------------
    // Checks
    // --------------------

    reset_output_zero: assert property (@(posedge clk_i) rst_d_q |-> code_o == '0)
        else report_mismatch("code_o", 32'h0, 32'($sampled(code_o)));

    listed_entry_exact: assert property (@(posedge clk_i) hit_q |-> code_o == exp_q)
        else report_mismatch("code_o", 32'($sampled(exp_q)), 32'($sampled(code_o)));

    unlisted_gives_miss: assert property (@(posedge clk_i) miss_q |-> code_o == '0)
        else report_mismatch("code_o", 32'h0, 32'($sampled(code_o)));

    match_len_range: assert property (@(posedge clk_i)
        started_q && code_o.match |-> code_o.len >= 5'd1 && code_o.len <= 5'd20)
        else report_mismatch("code_o.len", 32'd20, 32'($sampled(code_o.len)));

    match_bits_fit: assert property (@(posedge clk_i)
        started_q && code_o.match |-> (code_o.bits >> code_o.len) == '0)
        else report_mismatch("code_o.bits", 32'h0, 32'($sampled(code_o.bits)));

    nomatch_all_zero: assert property (@(posedge clk_i)
        started_q && !code_o.match |-> code_o.len == '0 && code_o.bits == '0)
        else report_mismatch("code_o", 32'h0, 32'($sampled(code_o)));

    // --------------------
    // Clock, reset and stimulus
    // --------------------

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Timeout: the run did not end within %0d cycles.", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        codebook_sym_pkg::sym_group_t grp;
        ref_entry_t                   entry;
        logic [31:0]                  raw;
        int                           i;
        lfsr_state = 32'd26;
        rst_n_i    = 1'b0;
        sym_i      = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);  // The idle group at release must also read as zero.

        // Directed entries, back to back.
        for (i = 0; i < N_REF; i++) begin
            entry = ref_tab[i];
            sym_i <= entry.grp;
            groups++;
            @(posedge clk_i);
        end

        // Half valid counts with keys cut to the count, half any count.
        for (i = 0; i < N_RAND; i++) begin
            draw_bits(1, raw);
            if (raw[0]) begin
                draw_bits(3, raw);
                grp.cnt = {3'b000, raw[2:0]} + 6'd1;
            end else begin
                draw_bits(6, raw);
                grp.cnt = raw[5:0];
            end
            draw_bits(32, raw);
            grp.key = raw;
            if (grp.cnt != '0 && grp.cnt <= `CB_CNT_MAX) begin
                grp.key = raw & digit_mask(grp.cnt);
            end
            sym_i <= grp;
            groups++;
            @(posedge clk_i);
        end

        sym_i <= '0;
        repeat (3) @(posedge clk_i);
        $display("Applied %0d groups in %0d cycles, %0d errors.", groups, cycle_cnt, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: src/codebook_encoder_b11.sv
`include "codebook_macros.svh"

module codebook_encoder_b11 (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  codebook_sym_pkg::sym_group_t    sym_i,
    output codebook_code_pkg::code_result_t code_o
);

    codebook_code_pkg::code_len_t  len;
    codebook_code_pkg::code_bits_t bits;

    // Both tables see the same group in the same cycle.
    codebook_length_rom length_rom_i (
        .sym_i (sym_i),
        .len_o (len)
    );

    codebook_codeword_rom codeword_rom_i (
        .sym_i  (sym_i),
        .bits_o (bits)
    );

    // One register stage, so the result shows one cycle after the group.
    codebook_output_stage output_stage_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .len_i   (len),
        .bits_i  (bits),
        .code_o  (code_o)
    );

endmodule

// File: src/codebook_output_stage.sv
`include "codebook_macros.svh"

module codebook_output_stage (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  codebook_code_pkg::code_len_t    len_i,
    input  codebook_code_pkg::code_bits_t   bits_i,
    output codebook_code_pkg::code_result_t code_o
);

    codebook_code_pkg::code_result_t result;

    // --------------------
    // Result assembly
    // --------------------

    // Every table entry has a nonzero length, so a zero length means no match.
    always_comb begin
        result.match = (len_i != '0);
        result.len   = len_i;
        result.bits  = result.match ? bits_i : '0;  // Keep stray bits off a miss.
    end

    // --------------------
    // Output register
    // --------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            code_o <= '0;
        end else begin
            code_o <= result;
        end
    end

endmodule

// File: src/codebook_codeword_rom.sv
`include "codebook_macros.svh"

module codebook_codeword_rom (
    input  codebook_sym_pkg::sym_group_t  sym_i,
    output codebook_code_pkg::code_bits_t bits_o
);

    logic cnt_ok;

    assign cnt_ok = (sym_i.cnt != '0) && (sym_i.cnt <= `CB_CNT_MAX);

    // Same selection as the length table. Codewords sit right-aligned.
    always_comb begin
        bits_o = '0;
        if (cnt_ok) begin
            case (sym_i.cnt)
                'd1: case (sym_i.key)
                    'h1:     bits_o = 'b10000;
                    'hF:     bits_o = 'b11111111110100;
                    default: bits_o = '0;
                endcase
                'd2: case (sym_i.key)
                    'h21:    bits_o = 'b11111010000;
                    'h22:    bits_o = 'b11111010001;
                    'h0F:    bits_o = 'b11111111110101;
                    'h2F:    bits_o = 'b11111111111111101100;
                    default: bits_o = '0;
                endcase
                'd3: case (sym_i.key)
                    'h002:   bits_o = 'b100010;
                    'h200:   bits_o = 'b100100;
                    'h020:   bits_o = 'b100011;
                    'h201:   bits_o = 'b11111010110;
                    'h011:   bits_o = 'b11111010010;
                    'h202:   bits_o = 'b11111010111;
                    'h012:   bits_o = 'b11111010011;
                    'h021:   bits_o = 'b11111010100;
                    'h022:   bits_o = 'b11111010101;
                    'h00F:   bits_o = 'b11111111110110;
                    'h01F:   bits_o = 'b1111111111111110000;
                    'h20F:   bits_o = 'b11111111111111101110;
                    'h02F:   bits_o = 'b11111111111111101101;
                    default: bits_o = '0;
                endcase
                'd4: case (sym_i.key)
                    'h0002:  bits_o = 'b100101;
                    'h0102:  bits_o = 'b11111011011;
                    'h0011:  bits_o = 'b11111011000;
                    'h0012:  bits_o = 'b11111011001;
                    'h0101:  bits_o = 'b11111011010;
                    'h000F:  bits_o = 'b11111111110111;
                    'h010F:  bits_o = 'b1111111111111110010;
                    'h001F:  bits_o = 'b1111111111111110001;
                    default: bits_o = '0;
                endcase
                'd5: case (sym_i.key)
                    'h00002: bits_o = 'b100110;
                    'h00102: bits_o = 'b11111011111;
                    'h00011: bits_o = 'b11111011100;
                    'h01001: bits_o = 'b11111100000;
                    'h00012: bits_o = 'b11111011101;
                    'h01002: bits_o = 'b11111100001;
                    'h00101: bits_o = 'b11111011110;
                    'h0000F: bits_o = 'b11111111111000;
                    'h0010F: bits_o = 'b1111111111111110100;
                    'h0100F: bits_o = 'b1111111111111110101;
                    'h0001F: bits_o = 'b1111111111111110011;
                    default: bits_o = '0;
                endcase
                'd6: case (sym_i.key)
                    'h000002: bits_o = 'b100111;
                    'h000101: bits_o = 'b11111100100;
                    'h000102: bits_o = 'b11111100101;
                    'h000011: bits_o = 'b11111100010;
                    'h001001: bits_o = 'b11111100110;
                    'h000012: bits_o = 'b11111100011;
                    'h001002: bits_o = 'b11111100111;
                    'h010001: bits_o = 'b11111101000;
                    'h010002: bits_o = 'b11111101001;
                    'h00000F: bits_o = 'b11111111111001;
                    'h00010F: bits_o = 'b11111111111111110000;
                    'h00100F: bits_o = 'b11111111111111110001;
                    'h00001F: bits_o = 'b11111111111111101111;
                    'h01000F: bits_o = 'b11111111111111110010;
                    default:  bits_o = '0;
                endcase
                'd7: case (sym_i.key)
                    'h0000002: bits_o = 'b101000;
                    'h0001000: bits_o = 'b101010;
                    'h0010000: bits_o = 'b101011;
                    'h0000100: bits_o = 'b101001;
                    'h0000101: bits_o = 'b11111101100;
                    'h0000102: bits_o = 'b11111101101;
                    'h0000011: bits_o = 'b11111101010;
                    'h0001001: bits_o = 'b11111101110;
                    'h0000012: bits_o = 'b11111101011;
                    'h0001002: bits_o = 'b11111101111;
                    'h0010001: bits_o = 'b11111110000;
                    'h0010002: bits_o = 'b11111110001;
                    'h0100001: bits_o = 'b11111110010;
                    'h0100002: bits_o = 'b11111110011;
                    'h000000F: bits_o = 'b11111111111010;
                    'h000010F: bits_o = 'b11111111111111110100;
                    'h000100F: bits_o = 'b11111111111111110101;
                    'h000001F: bits_o = 'b11111111111111110011;
                    'h001000F: bits_o = 'b11111111111111110110;
                    'h010000F: bits_o = 'b11111111111111110111;
                    default:   bits_o = '0;
                endcase
                'd8: case (sym_i.key)
                    'h00000001: bits_o = 'b101100;
                    'h00000002: bits_o = 'b101101;
                    'h00000010: bits_o = 'b101110;
                    'h01000000: bits_o = 'b110000;
                    'h00000100: bits_o = 'b101111;
                    'h00000101: bits_o = 'b11111110110;
                    'h00000102: bits_o = 'b11111110111;
                    'h00000011: bits_o = 'b11111110100;
                    'h00000012: bits_o = 'b11111110101;
                    'h01000001: bits_o = 'b11111111000;
                    'h01000002: bits_o = 'b111111110010;
                    'h0000000F: bits_o = 'b111111111110110;
                    'h0000010F: bits_o = 'b11111111111111111001;
                    'h0000001F: bits_o = 'b11111111111111111000;
                    'h0100000F: bits_o = 'b11111111111111111010;
                    default:    bits_o = '0;
                endcase
                default: bits_o = '0;
            endcase
        end
    end

endmodule

// File: src/codebook_length_rom.sv
`include "codebook_macros.svh"

module codebook_length_rom (
    input  codebook_sym_pkg::sym_group_t sym_i,
    output codebook_code_pkg::code_len_t len_o
);

    logic cnt_ok;

    assign cnt_ok = (sym_i.cnt != '0) && (sym_i.cnt <= `CB_CNT_MAX);

    // The count picks the sub-table, the key picks the entry within it.
    always_comb begin
        len_o = '0;
        if (cnt_ok) begin
            case (sym_i.cnt)
                'd1: case (sym_i.key)
                    'h1:      len_o = 'd5;
                    'hF:      len_o = 'd14;
                    default:  len_o = '0;
                endcase
                'd2: case (sym_i.key)
                    'h21, 'h22: len_o = 'd11;
                    'h0F:       len_o = 'd14;
                    'h2F:       len_o = 'd20;
                    default:    len_o = '0;
                endcase
                'd3: case (sym_i.key)
                    'h002, 'h200, 'h020:                      len_o = 'd6;
                    'h201, 'h011, 'h202, 'h012, 'h021, 'h022: len_o = 'd11;
                    'h00F:                                    len_o = 'd14;
                    'h01F:                                    len_o = 'd19;
                    'h20F, 'h02F:                             len_o = 'd20;
                    default:                                  len_o = '0;
                endcase
                'd4: case (sym_i.key)
                    'h0002:                         len_o = 'd6;
                    'h0102, 'h0011, 'h0012, 'h0101: len_o = 'd11;
                    'h000F:                         len_o = 'd14;
                    'h010F, 'h001F:                 len_o = 'd19;
                    default:                        len_o = '0;
                endcase
                'd5: case (sym_i.key)
                    'h00002: len_o = 'd6;
                    'h00102, 'h00011, 'h01001,
                    'h00012, 'h01002, 'h00101: len_o = 'd11;
                    'h0000F: len_o = 'd14;
                    'h0010F, 'h0100F, 'h0001F: len_o = 'd19;
                    default: len_o = '0;
                endcase
                'd6: case (sym_i.key)
                    'h000002: len_o = 'd6;
                    'h000101, 'h000102, 'h000011, 'h001001,
                    'h000012, 'h001002, 'h010001, 'h010002: len_o = 'd11;
                    'h00000F: len_o = 'd14;
                    'h00010F, 'h00100F, 'h00001F, 'h01000F: len_o = 'd20;
                    default:  len_o = '0;
                endcase
                'd7: case (sym_i.key)
                    'h0000002, 'h0001000, 'h0010000, 'h0000100: len_o = 'd6;
                    'h0000101, 'h0000102, 'h0000011, 'h0001001, 'h0000012,
                    'h0001002, 'h0010001, 'h0010002, 'h0100001, 'h0100002: len_o = 'd11;
                    'h000000F: len_o = 'd14;
                    'h000010F, 'h000100F, 'h000001F,
                    'h001000F, 'h010000F: len_o = 'd20;
                    default:   len_o = '0;
                endcase
                'd8: case (sym_i.key)
                    'h00000001, 'h00000002, 'h00000010,
                    'h01000000, 'h00000100: len_o = 'd6;
                    'h00000101, 'h00000102, 'h00000011,
                    'h00000012, 'h01000001: len_o = 'd11;
                    'h01000002: len_o = 'd12;
                    'h0000000F: len_o = 'd15;  // Longer than the 14 of the shorter groups.
                    'h0000010F, 'h0000001F, 'h0100000F: len_o = 'd20;
                    default:    len_o = '0;
                endcase
                default: len_o = '0;
            endcase
        end
    end

endmodule

// File: src/codebook_code_pkg.sv
`include "codebook_macros.svh"

package codebook_code_pkg;

    // --------------------
    // Codeword types
    // --------------------

    typedef logic [`CB_LEN_W-1:0] code_len_t;  // Zero means the group has no entry.

    // Codeword bits, right-aligned in the field.
    typedef logic [`CB_CODE_W-1:0] code_bits_t;

    // Registered lookup result.
    typedef struct packed {
        logic       match;
        code_len_t  len;
        code_bits_t bits;
    } code_result_t;

endpackage

// File: src/codebook_sym_pkg.sv
`include "codebook_macros.svh"

package codebook_sym_pkg;

    // --------------------
    // Symbol group types
    // --------------------

    // How many symbols the key holds.
    typedef logic [`CB_CNT_W-1:0] sym_cnt_t;

    // Symbols packed as hex digits, the last symbol in the lowest digit.
    typedef logic [`CB_KEY_W-1:0] sym_key_t;

    // One group as it enters the encoder.
    typedef struct packed {
        sym_cnt_t cnt;
        sym_key_t key;
    } sym_group_t;

endpackage

// File: src/codebook_macros.svh
`ifndef CODEBOOK_MACROS_SVH
`define CODEBOOK_MACROS_SVH

// --------------------
// Symbol group input
// --------------------

// Number of symbols in a group.
`define CB_CNT_W 6

// Eight 4-bit symbols packed as hex digits.
`define CB_KEY_W 32

// Groups longer than this never match.
`define CB_CNT_MAX 8

// --------------------
// Codeword output
// --------------------

`define CB_LEN_W 5  // Holds lengths up to 20 bits.

`define CB_CODE_W 21  // Right-aligned codeword field.

`endif
